//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := dcache_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir
PASS_MSG := === PASS ===

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+hw
hw/dcache_pkg.sv
hw/way_if.sv
hw/dcache_ways.sv
hw/line_buffer.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verification/dcache_checker.sv
verification/dcache_tb.sv

//--- hw/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cpu side widths
`define DC_ADDR_W     32
`define DC_DATA_W     32

// geometry: 8 sets x 4 ways x 32-byte lines
`define DC_SETS       8
`define DC_WAYS       4
`define DC_OFFSET_W   5   // byte offset inside a line
`define DC_INDEX_W    3   // log2 of DC_SETS
`define DC_TAG_W      24  // addr - index - offset
`define DC_LINE_W     256
`define DC_BEATS      8   // words per line, one per burst beat
`define DC_BURST_LEN  7   // memory burst length code, beats - 1

// lru age per way, log2 of DC_WAYS
`define DC_AGE_W      2

`endif

//--- hw/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_ctrl (
  input  logic              clk,
  input  logic              rst,
  way_if.ctrl               ways,

  // cpu request / response
  input  logic              req_valid,
  input  logic              req_wr,
  input  dcache_pkg::addr_t req_addr,
  output logic              req_ready,
  output logic              rsp_valid,
  input  logic              rsp_ready,

  // memory read channels
  output logic              rd_req_valid,
  output dcache_pkg::addr_t rd_req_addr,
  input  logic              rd_req_ready,
  input  logic              rd_rsp_valid,
  input  logic              rd_rsp_last,
  output logic              rd_rsp_ready,

  // memory write channels
  output logic              wr_req_valid,
  output dcache_pkg::addr_t wr_req_addr,
  input  logic              wr_req_ready,
  output logic              wr_data_valid,
  input  logic              wr_data_ready,

  // line buffer control
  output logic              buf_load,
  output logic              buf_shift_in,
  output logic              buf_shift_out,
  input  logic              buf_wb_last
);
  import dcache_pkg::*;

  // every request moves a full line: len code 7 -> 8 beats
  localparam int unsigned REQ_BEATS = `DC_BURST_LEN + 1;

  dc_state_e state;
  dc_state_e state_nxt;
  index_t    index;

  generate
    if (REQ_BEATS != `DC_BEATS) begin : g_len_chk
      $error("burst length code does not match the line size");
    end
  endgenerate

  assign index = req_addr[`DC_OFFSET_W +: `DC_INDEX_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= WAIT_CPU;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      WAIT_CPU: begin
        if (req_valid) begin
          if (ways.hit)
            state_nxt = req_wr ? W_HIT : R_HIT;
          else
            state_nxt = ways.victim_dirty ? WB_REQ : RF_REQ;  // clean victim skips write-back
        end
      end
      R_HIT:     state_nxt = SEND_DATA;
      W_HIT:     state_nxt = WAIT_CPU;
      SEND_DATA: if (rsp_ready) state_nxt = WAIT_CPU;  // hold under back-pressure
      WB_REQ:    if (wr_req_ready) state_nxt = WB_DATA;
      WB_DATA: begin
        if (wr_data_ready && buf_wb_last)
          state_nxt = RF_REQ;
      end
      RF_REQ:    if (rd_req_ready) state_nxt = RF_DATA;
      RF_DATA: begin
        if (rd_rsp_valid && rd_rsp_last)
          state_nxt = RF_WRITE;
      end
      RF_WRITE:  state_nxt = req_wr ? W_HIT : R_HIT;  // replay as a hit
      default:   state_nxt = WAIT_CPU;
    endcase
  end

  // cpu side
  assign req_ready = (state == R_HIT) || (state == W_HIT);  // one-cycle pulse
  assign rsp_valid = (state == SEND_DATA);

  // way array commands
  assign ways.touch     = (state == WAIT_CPU) && req_valid && ways.hit;
  assign ways.hit_wr    = (state == W_HIT);
  assign ways.refill_wr = (state == RF_WRITE);

  // write-back path
  assign wr_req_valid  = (state == WB_REQ);
  assign wr_req_addr   = {ways.victim_tag, index, {`DC_OFFSET_W{1'b0}}};
  assign wr_data_valid = (state == WB_DATA);
  assign buf_load      = (state == WB_REQ);  // victim stable while the request waits
  assign buf_shift_out = (state == WB_DATA) && wr_data_ready;

  // refill path, line-aligned cpu address
  assign rd_req_valid = (state == RF_REQ);
  assign rd_req_addr  = {req_addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
  assign rd_rsp_ready = (state == RF_DATA);
  assign buf_shift_in = (state == RF_DATA) && rd_rsp_valid;

endmodule

`default_nettype wire

//--- hw/dcache_pkg.sv
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

  // controller states, one per step of a hit or a miss
  typedef enum logic [3:0] {
    WAIT_CPU,   // idle, lookup on a valid request
    R_HIT,      // read accepted
    W_HIT,      // write merged into the hit way
    SEND_DATA,  // read data held until the cpu takes it
    WB_REQ,     // dirty victim, write-back request
    WB_DATA,    // 8 write-back beats
    RF_REQ,     // refill request
    RF_DATA,    // 8 refill beats
    RF_WRITE    // buffered line into the victim way
  } dc_state_e;

  typedef logic [`DC_ADDR_W-1:0]     addr_t;
  typedef logic [`DC_DATA_W-1:0]     word_t;
  typedef logic [`DC_LINE_W-1:0]     line_t;
  typedef logic [`DC_TAG_W-1:0]      tag_t;
  typedef logic [`DC_INDEX_W-1:0]    index_t;
  typedef logic [$clog2(`DC_WAYS)-1:0] way_idx_t;
  typedef logic [`DC_DATA_W/8-1:0]   wstrb_t;  // one bit per byte lane

endpackage

`default_nettype wire

//--- hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_top (
  input  logic               clk,
  input  logic               rst,

  // cpu request
  input  logic               mem_req_valid,
  input  logic               mem_req_wr,      // 1 write, 0 read
  input  dcache_pkg::addr_t  mem_req_addr,
  input  dcache_pkg::word_t  mem_req_wdata,
  input  dcache_pkg::wstrb_t mem_req_wstrb,
  output logic               mem_req_ready,

  // cpu read response
  output logic               cache_rsp_valid,
  output dcache_pkg::word_t  cache_rsp_data,
  input  logic               cache_rsp_ready,

  // memory read, always 8-beat bursts
  output logic               rd_req_valid,
  output dcache_pkg::addr_t  rd_req_addr,
  input  logic               rd_req_ready,
  input  logic               rd_rsp_valid,
  input  dcache_pkg::word_t  rd_rsp_data,
  input  logic               rd_rsp_last,
  output logic               rd_rsp_ready,

  // memory write, always 8 beats with all strobes set
  output logic               wr_req_valid,
  output dcache_pkg::addr_t  wr_req_addr,
  input  logic               wr_req_ready,
  output logic               wr_data_valid,
  output dcache_pkg::word_t  wr_data,
  output logic               wr_data_last,
  input  logic               wr_data_ready
);
  import dcache_pkg::*;

  tag_t                    tag;
  index_t                  index;
  logic [`DC_OFFSET_W-1:2] word_off;
  line_t                   victim_line;
  line_t                   buf_line;
  logic                    buf_load;
  logic                    buf_shift_in;
  logic                    buf_shift_out;

  // address fields
  assign tag      = mem_req_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign index    = mem_req_addr[`DC_OFFSET_W +: `DC_INDEX_W];
  assign word_off = mem_req_addr[`DC_OFFSET_W-1:2];

  way_if way_bus ();

  dcache_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .ways          (way_bus.ctrl),
    .req_valid     (mem_req_valid),
    .req_wr        (mem_req_wr),
    .req_addr      (mem_req_addr),
    .req_ready     (mem_req_ready),
    .rsp_valid     (cache_rsp_valid),
    .rsp_ready     (cache_rsp_ready),
    .rd_req_valid  (rd_req_valid),
    .rd_req_addr   (rd_req_addr),
    .rd_req_ready  (rd_req_ready),
    .rd_rsp_valid  (rd_rsp_valid),
    .rd_rsp_last   (rd_rsp_last),
    .rd_rsp_ready  (rd_rsp_ready),
    .wr_req_valid  (wr_req_valid),
    .wr_req_addr   (wr_req_addr),
    .wr_req_ready  (wr_req_ready),
    .wr_data_valid (wr_data_valid),
    .wr_data_ready (wr_data_ready),
    .buf_load      (buf_load),
    .buf_shift_in  (buf_shift_in),
    .buf_shift_out (buf_shift_out),
    .buf_wb_last   (wr_data_last)   // last beat flag goes straight to memory
  );

  line_buffer u_buf (
    .clk         (clk),
    .rst         (rst),
    .load        (buf_load),
    .victim_line (victim_line),
    .shift_in    (buf_shift_in),
    .shift_out   (buf_shift_out),
    .beat_in     (rd_rsp_data),
    .line        (buf_line),
    .beat        (wr_data),
    .wb_last     (wr_data_last)
  );

  dcache_ways u_ways (
    .clk         (clk),
    .rst         (rst),
    .ctl         (way_bus.ways),
    .index       (index),
    .tag         (tag),
    .offset      (word_off),
    .cpu_wdata   (mem_req_wdata),
    .cpu_wstrb   (mem_req_wstrb),
    .refill_line (buf_line),
    .victim_line (victim_line),
    .rd_word     (cache_rsp_data)
  );

endmodule

`default_nettype wire

//--- hw/dcache_ways.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_ways (
  input  logic                clk,
  input  logic                rst,
  way_if.ways                 ctl,
  input  dcache_pkg::index_t  index,
  input  dcache_pkg::tag_t    tag,
  input  logic [`DC_OFFSET_W-1:2] offset,  // word within the line
  input  dcache_pkg::word_t   cpu_wdata,
  input  dcache_pkg::wstrb_t  cpu_wstrb,
  input  dcache_pkg::line_t   refill_line,
  output dcache_pkg::line_t   victim_line,
  output dcache_pkg::word_t   rd_word
);
  import dcache_pkg::*;

  localparam int AGE_W = `DC_AGE_W;
  localparam logic [AGE_W-1:0] OLDEST = '1;  // age 3 marks the lru way

  // per set, per way state
  logic             valid_q [`DC_SETS][`DC_WAYS];
  logic             dirty_q [`DC_SETS][`DC_WAYS];
  tag_t             tag_q   [`DC_SETS][`DC_WAYS];
  line_t            data_q  [`DC_SETS][`DC_WAYS];
  logic [AGE_W-1:0] age_q   [`DC_SETS][`DC_WAYS];

  logic [`DC_WAYS-1:0] way_hit;
  way_idx_t            hit_way;
  way_idx_t            victim;
  way_idx_t            acc_way;   // way made most recent this cycle
  logic [AGE_W-1:0]    acc_age;
  line_t               hit_line;
  line_t               merge_line;

  // combinational lookup over all ways of the set
  always_comb begin
    way_hit = '0;
    hit_way = '0;
    victim  = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      way_hit[w] = valid_q[index][w] && (tag_q[index][w] == tag);
      if (way_hit[w]) hit_way = way_idx_t'(w);
      if (age_q[index][w] == OLDEST) victim = way_idx_t'(w);  // ages stay a permutation
    end
  end

  assign ctl.hit          = |way_hit;
  assign ctl.victim_dirty = dirty_q[index][victim];  // dirty only ever set on a valid line
  assign ctl.victim_tag   = tag_q[index][victim];
  assign victim_line      = data_q[index][victim];
  assign hit_line         = data_q[index][hit_way];

  // byte merge of the cpu word into the hit line
  always_comb begin
    merge_line = hit_line;
    for (int b = 0; b < `DC_DATA_W/8; b++) begin
      if (cpu_wstrb[b])
        merge_line[offset*`DC_DATA_W + b*8 +: 8] = cpu_wdata[b*8 +: 8];
    end
  end

  // data and tag arrays
  always_ff @(posedge clk) begin
    if (ctl.refill_wr) begin
      data_q[index][victim] <= refill_line;
      tag_q[index][victim]  <= tag;
    end else if (ctl.hit_wr) begin
      data_q[index][hit_way] <= merge_line;  // tag unchanged on a hit
    end
  end

  // valid and dirty bits
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
          valid_q[s][w] <= 1'b0;
          dirty_q[s][w] <= 1'b0;
        end
      end
    end else if (ctl.refill_wr) begin
      valid_q[index][victim] <= 1'b1;
      dirty_q[index][victim] <= 1'b0;  // fresh line matches memory
    end else if (ctl.hit_wr) begin
      dirty_q[index][hit_way] <= 1'b1;
    end
  end

  // a refilled way counts as an access too, otherwise it would stay the victim
  assign acc_way = ctl.refill_wr ? victim : hit_way;
  assign acc_age = age_q[index][acc_way];

  // true lru: accessed way -> 0, every younger way ages by one
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
          age_q[s][w] <= AGE_W'(w);  // 0..3 by way number
        end
      end
    end else if (ctl.touch || ctl.refill_wr) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        if (way_idx_t'(w) == acc_way)
          age_q[index][w] <= '0;
        else if (age_q[index][w] < acc_age)
          age_q[index][w] <= age_q[index][w] + 1'b1;
      end
    end
  end

  // read word captured while the cpu still holds the address
  always_ff @(posedge clk) begin
    if (ctl.refill_wr)
      rd_word <= refill_line[offset*`DC_DATA_W +: `DC_DATA_W];
    else if (ctl.touch)
      rd_word <= hit_line[offset*`DC_DATA_W +: `DC_DATA_W];
  end

endmodule

`default_nettype wire

//--- hw/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

// one line in flight between memory and the way arrays
module line_buffer (
  input  logic              clk,
  input  logic              rst,
  input  logic              load,         // capture victim line
  input  dcache_pkg::line_t victim_line,
  input  logic              shift_in,     // take one refill beat
  input  logic              shift_out,    // advance one write-back beat
  input  dcache_pkg::word_t beat_in,
  output dcache_pkg::line_t line,
  output dcache_pkg::word_t beat,
  output logic              wb_last
);

  localparam int CNT_W = $clog2(`DC_BEATS);
  localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`DC_BEATS - 1);

  logic [CNT_W-1:0] beat_cnt;  // write-back beats sent so far

  // both directions shift right by one word
  // refill enters at the top, so beat 0 lands in word 0 after 8 beats
  always_ff @(posedge clk) begin
    if (load)
      line <= victim_line;
    else if (shift_in)
      line <= {beat_in, line[`DC_LINE_W-1:`DC_DATA_W]};
    else if (shift_out)
      line <= {{`DC_DATA_W{1'b0}}, line[`DC_LINE_W-1:`DC_DATA_W]};  // word 0 goes first
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (load) begin
      beat_cnt <= '0;
    end else if (shift_out) begin
      beat_cnt <= beat_cnt + 1'b1;  // wraps to 0 after the 8th beat
    end
  end

  assign beat    = line[`DC_DATA_W-1:0];
  assign wb_last = (beat_cnt == LAST_BEAT);  // only reached inside a write-back

endmodule

`default_nettype wire

//--- hw/way_if.sv
`timescale 1ns/1ps
`default_nettype none

// link between the controller and the way arrays
interface way_if;
  import dcache_pkg::*;

  // controller -> ways
  logic hit_wr;        // merge cpu word into hit way, mark dirty
  logic refill_wr;     // line buffer into victim way, clean + valid
  logic touch;         // lookup hit in idle, update ages

  // ways -> controller
  logic hit;           // some valid way matches the tag
  logic victim_dirty;  // victim needs a write-back
  tag_t victim_tag;    // for the write-back address

  modport ctrl (
    output hit_wr, refill_wr, touch,
    input  hit, victim_dirty, victim_tag
  );

  modport ways (
    input  hit_wr, refill_wr, touch,
    output hit, victim_dirty, victim_tag
  );

endinterface

`default_nettype wire

//--- verification/dcache_checker.sv
`timescale 1ns/1ps
`default_nettype none

// handshake rules on the cache ports
module dcache_checker (
  input logic clk,
  input logic rst,
  input logic mem_req_valid,
  input logic mem_req_ready,
  input logic cache_rsp_valid,
  input logic cache_rsp_ready,
  input logic rd_req_valid,
  input logic rd_req_ready,
  input logic rd_rsp_valid,
  input logic rd_rsp_ready,
  input logic wr_req_valid,
  input logic wr_req_ready,
  input logic wr_data_valid,
  input logic wr_data_ready,
  input logic wr_data_last
);

  // a valid stays up until its ready
  req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid && !mem_req_ready |=> mem_req_valid)
    else $error("mem_req_valid dropped before mem_req_ready");
  rsp_hold: assert property (@(posedge clk) disable iff (rst)
    cache_rsp_valid && !cache_rsp_ready |=> cache_rsp_valid)
    else $error("cache_rsp_valid dropped before cache_rsp_ready");
  rd_req_hold: assert property (@(posedge clk) disable iff (rst)
    rd_req_valid && !rd_req_ready |=> rd_req_valid)
    else $error("rd_req_valid dropped before rd_req_ready");
  rd_rsp_hold: assert property (@(posedge clk) disable iff (rst)
    rd_rsp_valid && !rd_rsp_ready |=> rd_rsp_valid)
    else $error("rd_rsp_valid dropped before rd_rsp_ready");
  wr_req_hold: assert property (@(posedge clk) disable iff (rst)
    wr_req_valid && !wr_req_ready |=> wr_req_valid)
    else $error("wr_req_valid dropped before wr_req_ready");
  wr_data_hold: assert property (@(posedge clk) disable iff (rst)
    wr_data_valid && !wr_data_ready |=> wr_data_valid)
    else $error("wr_data_valid dropped before wr_data_ready");

  // one memory request at a time
  req_excl: assert property (@(posedge clk) disable iff (rst) !(rd_req_valid && wr_req_valid))
    else $error("rd_req_valid and wr_req_valid high together");

  last_valid: assert property (@(posedge clk) disable iff (rst) wr_data_last |-> wr_data_valid)
    else $error("wr_data_last without wr_data_valid");

endmodule

bind dcache_top dcache_checker u_checker (.*);

`default_nettype wire

//--- verification/dcache_patterns.txt
# op addr wdata wstrb expected_read   (hex, op 0 = read, 1 = write)
# a word never written reads as addr ^ 5a5a0000, expected column unused on writes
0 00001024 00000000 0 5a5a1024
0 0000103c 00000000 0 5a5a103c
1 00001028 deadbeef 3 00000000
0 00001028 00000000 0 5a5abeef
1 00001030 11223344 c 00000000
0 00001030 00000000 0 11221030
0 00002020 00000000 0 5a5a2020
0 00003024 00000000 0 5a5a3024
1 00004028 cafef00d f 00000000
0 00005020 00000000 0 5a5a5020
0 00001028 00000000 0 5a5abeef
0 00003024 00000000 0 5a5a3024
0 00006020 00000000 0 5a5a6020
0 00004028 00000000 0 cafef00d
0 00001030 00000000 0 11221030
1 00000048 aabbccdd 4 00000000
0 00000048 00000000 0 5abb0048
0 0000004c 00000000 0 5a5a004c
0 000070e0 00000000 0 5a5a70e0
0 000070fc 00000000 0 5a5a70fc
0 12345680 00000000 0 486e5680
1 12345684 01020304 f 00000000
0 12345684 00000000 0 01020304
0 000070e4 00000000 0 5a5a70e4
0 0000103c 00000000 0 5a5a103c

//--- verification/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_tb;
  import dcache_pkg::*;

  localparam int    TIMEOUT      = 2000;  // cycles allowed per wait loop
  localparam string PATTERN_FILE = "verification/dcache_patterns.txt";

  logic   clk = 1'b0;
  logic   rst;
  logic   mem_req_valid, mem_req_wr, mem_req_ready;
  addr_t  mem_req_addr;
  word_t  mem_req_wdata;
  wstrb_t mem_req_wstrb;
  logic   cache_rsp_valid, cache_rsp_ready;
  word_t  cache_rsp_data;
  logic   rd_req_valid, rd_req_ready, rd_rsp_valid, rd_rsp_last, rd_rsp_ready;
  addr_t  rd_req_addr;
  word_t  rd_rsp_data;
  logic   wr_req_valid, wr_req_ready, wr_data_valid, wr_data_last, wr_data_ready;
  addr_t  wr_req_addr;
  word_t  wr_data;

  // memory model state
  word_t mem    [addr_t];  // words written back by the cache
  word_t shadow [addr_t];  // cpu view, every write applied
  addr_t rd_log [$];       // refill addresses since the last request
  addr_t wr_log [$];       // write-back addresses since the last request
  addr_t rd_base, wb_base;
  int    rd_beat, wb_beat;
  logic  rd_busy, wb_busy;

  // reference cache, per set most recent first
  tag_t mdl_tag   [`DC_SETS][`DC_WAYS];
  logic mdl_dirty [`DC_SETS][`DC_WAYS];
  int   mdl_cnt   [`DC_SETS];

  always #2 clk = ~clk;  // 4 ns

  dcache_top UUT (.*);

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t init_word(input addr_t a);
    return a ^ 32'h5a5a_0000;  // untouched memory
  endfunction

  function automatic word_t mem_read(input addr_t a);
    return mem.exists(a) ? mem[a] : init_word(a);
  endfunction

  function automatic word_t expect_word(input addr_t a);
    return shadow.exists(a) ? shadow[a] : init_word(a);
  endfunction

  task automatic shadow_write(input addr_t a, input word_t wd, input wstrb_t ws);
    addr_t wa;
    word_t w;
    wa = {a[`DC_ADDR_W-1:2], 2'b00};
    w  = expect_word(wa);
    for (int b = 0; b < `DC_DATA_W/8; b++) begin
      if (ws[b]) w[b*8 +: 8] = wd[b*8 +: 8];  // byte lanes with strobe only
    end
    shadow[wa] = w;
  endtask

  // true lru over the valid lines, invalid ways fill first
  task automatic model_access(input addr_t a, input logic wr, output logic miss,
                              output logic wb, output addr_t wb_addr);
    int   s;
    int   pos;
    tag_t t;
    logic d;
    s       = int'(a[`DC_OFFSET_W +: `DC_INDEX_W]);
    t       = a[`DC_ADDR_W-1 -: `DC_TAG_W];
    pos     = -1;
    wb      = 1'b0;
    wb_addr = '0;
    for (int i = 0; i < mdl_cnt[s]; i++) begin
      if (mdl_tag[s][i] == t) pos = i;
    end
    miss = (pos < 0);
    d    = 1'b0;
    if (miss) begin
      if (mdl_cnt[s] == `DC_WAYS) begin
        pos     = `DC_WAYS - 1;  // oldest entry leaves
        wb      = mdl_dirty[s][pos];
        wb_addr = {mdl_tag[s][pos], a[`DC_OFFSET_W +: `DC_INDEX_W], {`DC_OFFSET_W{1'b0}}};
      end else begin
        pos = mdl_cnt[s];
        mdl_cnt[s]++;
      end
    end else begin
      d = mdl_dirty[s][pos];
    end
    for (int i = pos; i > 0; i--) begin  // shift younger entries down
      mdl_tag[s][i]   = mdl_tag[s][i-1];
      mdl_dirty[s][i] = mdl_dirty[s][i-1];
    end
    mdl_tag[s][0]   = t;
    mdl_dirty[s][0] = d | wr;
  endtask

  // one cpu request, read data checked against the pattern
  task automatic cpu_access(input logic wr, input addr_t a, input word_t wd,
                            input wstrb_t ws, input word_t ex);
    int    t;
    logic  seen;
    word_t held;
    @(posedge clk);
    #1;
    mem_req_valid = 1'b1;
    mem_req_wr    = wr;
    mem_req_addr  = a;
    mem_req_wdata = wd;
    mem_req_wstrb = ws;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      assert (t < TIMEOUT)
        else abort_run($sformatf("timeout waiting for mem_req_ready at address 0x%08h", a));
    end while (!mem_req_ready);
    @(posedge clk);
    #1;
    mem_req_valid = 1'b0;
    if (!wr) begin
      t    = 0;
      seen = 1'b0;
      held = '0;
      do begin
        @(negedge clk);
        t++;
        assert (t < TIMEOUT)
          else abort_run($sformatf("timeout waiting for cache_rsp_valid at address 0x%08h", a));
        assert (!seen || (cache_rsp_valid && cache_rsp_data == held))
          else abort_run($sformatf("FAILED at %0t: response for 0x%08h dropped or changed",
                                   $time, a));
        if (cache_rsp_valid && !seen) begin
          seen = 1'b1;
          held = cache_rsp_data;  // must stay put under back-pressure
        end
      end while (!(cache_rsp_valid && cache_rsp_ready));
      assert (cache_rsp_data == ex)
        else abort_run($sformatf("FAILED at %0t: read 0x%08h returned 0x%08h, expected 0x%08h",
                                 $time, a, cache_rsp_data, ex));
    end
  endtask

  // memory traffic of the last request against the reference cache
  task automatic check_traffic(input logic wr, input addr_t a);
    logic  miss;
    logic  wb;
    addr_t wb_addr;
    addr_t line_addr;
    line_addr = {a[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    model_access(a, wr, miss, wb, wb_addr);
    if (miss) begin
      assert (rd_log.size() == 1 && rd_log[0] == line_addr)
        else abort_run($sformatf("FAILED at %0t: miss on 0x%08h needs one refill from 0x%08h",
                                 $time, a, line_addr));
    end else begin
      assert (rd_log.size() == 0)
        else abort_run($sformatf("FAILED at %0t: hit on 0x%08h issued a refill", $time, a));
    end
    if (wb) begin
      assert (wr_log.size() == 1 && wr_log[0] == wb_addr && wb_beat == `DC_BEATS)
        else abort_run($sformatf("FAILED at %0t: expected one 8-beat write-back to 0x%08h",
                                 $time, wb_addr));
    end else begin
      assert (wr_log.size() == 0)
        else abort_run($sformatf("FAILED at %0t: unexpected write-back on 0x%08h", $time, a));
    end
    assert (!rd_busy && !wb_busy)
      else abort_run("a memory burst was still open after the request finished");
    rd_log.delete();
    wr_log.delete();
  endtask

  // memory side and rsp back-pressure, sampled at negedge, driven after posedge
  initial begin : memory_model
    logic [31:0] rnd;
    logic        rd_req_fire, rd_rsp_fire, wr_req_fire, wr_data_fire;
    addr_t       wa;
    rnd             = 32'd5726;
    cache_rsp_ready = 1'b0;
    rd_req_ready    = 1'b0;
    rd_rsp_valid    = 1'b0;
    rd_rsp_data     = '0;
    rd_rsp_last     = 1'b0;
    wr_req_ready    = 1'b0;
    wr_data_ready   = 1'b0;
    rd_busy = 1'b0;
    wb_busy = 1'b0;
    rd_beat = 0;
    wb_beat = 0;
    rd_base = '0;
    wb_base = '0;
    forever begin
      @(negedge clk);
      rd_req_fire  = rd_req_valid && rd_req_ready;
      rd_rsp_fire  = rd_rsp_valid && rd_rsp_ready;
      wr_req_fire  = wr_req_valid && wr_req_ready;
      wr_data_fire = wr_data_valid && wr_data_ready;
      // refill beats taken exactly while a read burst is open
      assert (rd_rsp_ready == rd_busy)
        else abort_run($sformatf("FAILED at %0t: rd_rsp_ready is %0b, expected %0b",
                                 $time, rd_rsp_ready, rd_busy));
      if (wr_req_fire) begin
        wr_log.push_back(wr_req_addr);
        wb_busy = 1'b1;
        wb_base = wr_req_addr;
        wb_beat = 0;
      end
      if (wr_data_fire) begin
        wa = wb_base + addr_t'(4 * wb_beat);
        assert (wb_busy) else abort_run("write-back beat arrived with no open write request");
        assert (wr_data == expect_word(wa))
          else abort_run($sformatf("FAILED at %0t: write-back 0x%08h carried 0x%08h, exp 0x%08h",
                                   $time, wa, wr_data, expect_word(wa)));
        assert (wr_data_last == (wb_beat == `DC_BEATS - 1))
          else abort_run($sformatf("FAILED at %0t: wr_data_last wrong on beat %0d",
                                   $time, wb_beat));
        mem[wa] = wr_data;
        wb_beat++;
        if (wb_beat == `DC_BEATS) wb_busy = 1'b0;
      end
      if (rd_req_fire) begin
        rd_log.push_back(rd_req_addr);
        rd_busy = 1'b1;
        rd_base = rd_req_addr;
        rd_beat = 0;
      end
      if (rd_rsp_fire) begin
        rd_beat++;
        if (rd_beat == `DC_BEATS) rd_busy = 1'b0;
      end
      @(posedge clk);
      #1;
      rnd             = xorshift(rnd);
      cache_rsp_ready = rnd[0];
      rd_req_ready    = rnd[1] | rnd[2];  // ready about 3 of 4 cycles
      wr_req_ready    = rnd[3] | rnd[4];
      wr_data_ready   = rnd[5] | rnd[6];
      if (!rd_rsp_valid || rd_rsp_fire) begin  // a pending beat holds
        rd_rsp_valid = rd_busy && (rnd[7] | rnd[8]);
        rd_rsp_data  = mem_read(rd_base + addr_t'(4 * rd_beat));
        rd_rsp_last  = (rd_beat == `DC_BEATS - 1);
      end
    end
  end

  initial begin : main
    int          fd;
    int          ops;
    string       line;
    logic [31:0] op, a, wd, ws, ex;
    rst           = 1'b1;
    mem_req_valid = 1'b0;
    mem_req_wr    = 1'b0;
    mem_req_addr  = '0;
    mem_req_wdata = '0;
    mem_req_wstrb = '0;
    ops           = 0;
    for (int s = 0; s < `DC_SETS; s++) mdl_cnt[s] = 0;
    fd = $fopen(PATTERN_FILE, "r");
    assert (fd != 0) else abort_run("cannot open the pattern file");
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (5) begin  // idle, nothing may move
      @(negedge clk);
      assert (!mem_req_ready && !cache_rsp_valid && !rd_req_valid && !wr_req_valid
              && !wr_data_valid)
        else abort_run("a valid output or mem_req_ready rose with no request pending");
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) > 0 && $sscanf(line, "%h %h %h %h %h", op, a, wd, ws, ex) == 5) begin
        cpu_access(op[0], a, wd, ws[3:0], ex);
        check_traffic(op[0], a);
        if (op[0]) shadow_write(a, wd, ws[3:0]);
        ops++;
      end
    end
    $fclose(fd);
    assert (ops >= 20) else abort_run("the pattern file held too few operations");
    $display("%0d cpu operations checked", ops);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire
